// ==== verilog/dcpuPkg.sv ====
`default_nettype none

package dcpuPkg;

  //////////////////////////////////////////////////
  // Datapath widths
  //////////////////////////////////////////////////
  localparam int dataWidth   = 16; // Registers and data words
  localparam int opWidth     = 5;
  localparam int regIdxWidth = 3;
  localparam int numRegs     = 8;

  //////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////
  // General
  localparam logic [opWidth-1:0] opNop   = 5'b00000;
  localparam logic [opWidth-1:0] opHalt  = 5'b00001;

  // Data transfer
  localparam logic [opWidth-1:0] opLoad  = 5'b00010;
  localparam logic [opWidth-1:0] opStore = 5'b00011;
  localparam logic [opWidth-1:0] opLdil  = 5'b00100;
  localparam logic [opWidth-1:0] opLdih  = 5'b00101;

  // Control flow
  localparam logic [opWidth-1:0] opJump  = 5'b00110;
  localparam logic [opWidth-1:0] opBz    = 5'b01000;
  localparam logic [opWidth-1:0] opBnz   = 5'b01001;

  // Arithmetic
  localparam logic [opWidth-1:0] opAdd   = 5'b10000;
  localparam logic [opWidth-1:0] opAddi  = 5'b10001;
  localparam logic [opWidth-1:0] opSub   = 5'b10011;

  // Logic
  localparam logic [opWidth-1:0] opXor   = 5'b11001;
  localparam logic [opWidth-1:0] opAnd   = 5'b11010;
  localparam logic [opWidth-1:0] opOr    = 5'b11011;

  //////////////////////////////////////////////////
  // Instruction word
  //////////////////////////////////////////////////
  // Same 16 bits seen as register form or immediate form
  typedef union packed {
    struct packed {
      logic [opWidth-1:0]     opcode;
      logic [regIdxWidth-1:0] dest;
      logic                   spare;  // Unused
      logic [regIdxWidth-1:0] srcA;
      logic [3:0]             srcB;   // Low 3 bits name a register, nibble is LOAD/STORE offset
    } regForm;
    struct packed {
      logic [opWidth-1:0]     opcode;
      logic [regIdxWidth-1:0] dest;
      logic [7:0]             imm;
    } immForm;
  } instWord_t;

endpackage

`default_nettype wire

// ==== verilog/dcpuFetch.sv ====
`default_nettype none

module dcpuFetch import dcpuPkg::*; #(
  parameter int addrWidth = 8
) (
  input  wire logic                 CLK,
  input  wire logic                 RST,
  input  wire logic                 EN,
  input  wire logic                 Start,
  input  wire instWord_t            Inst,
  input  wire logic                 redirect,   // Taken jump/branch in memory stage
  input  wire logic [addrWidth-1:0] target,
  input  wire logic                 haltSeen,   // HALT sitting in write-back
  output logic [addrWidth-1:0]      InstMemAddr,
  output instWord_t                 fetchInst,
  output logic                      Running
);

  localparam logic stIdle = 1'b0;
  localparam logic stRun  = 1'b1;

  logic                 runState;
  logic                 nextState;
  logic [addrWidth-1:0] pc;
  logic [addrWidth-1:0] nextPc;

  //////////////////////////////////////////////////
  // Run state machine
  //////////////////////////////////////////////////
  always_comb begin
    nextState = runState;
    case (runState)
      stIdle: begin
        if (EN && Start) nextState = stRun;
      end
      stRun: begin
        // Either source stops the pipeline at the next edge
        if (!EN || haltSeen) nextState = stIdle;
      end
      default: nextState = stIdle;
    endcase
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      runState <= stIdle;
    end else begin
      runState <= nextState;
    end
  end

  assign Running = (runState == stRun);

  //////////////////////////////////////////////////
  // Program counter and fetch register
  //////////////////////////////////////////////////
  assign nextPc = redirect ? target : pc + 1'b1; // Redirect wins over sequential

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      pc        <= '0;
      fetchInst <= '0;  // Opcode zero is NOP
    end else if (Running) begin
      pc        <= nextPc;
      fetchInst <= Inst;
    end
  end

  assign InstMemAddr = pc;

  // Idle cycles leave the PC where it stopped, so a new Start resumes there
  assert property (@(posedge CLK) disable iff (RST) !Running |=> $stable(pc))
    else $error("PC moved while the CPU was idle");

endmodule

`default_nettype wire

// ==== verilog/dcpuRegFile.sv ====
`default_nettype none

module dcpuRegFile import dcpuPkg::*; (
  input  wire logic                   CLK,
  input  wire logic                   RST,
  input  wire logic [regIdxWidth-1:0] rdAddrA,
  input  wire logic [regIdxWidth-1:0] rdAddrB,
  input  wire logic [regIdxWidth-1:0] rdAddrC,
  input  wire logic                   wrEn,
  input  wire logic [regIdxWidth-1:0] wrAddr,
  input  wire logic [dataWidth-1:0]   wrData,
  output logic [dataWidth-1:0]        rdDataA,
  output logic [dataWidth-1:0]        rdDataB,
  output logic [dataWidth-1:0]        rdDataC
);

  logic [dataWidth-1:0] regs [numRegs];

  //////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wrAddr] <= wrData;
    end
  end

  //////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////
  // Combinational, decode samples them in the same cycle
  assign rdDataA = regs[rdAddrA];
  assign rdDataB = regs[rdAddrB];
  assign rdDataC = regs[rdAddrC]; // Dest register for STORE, ADDI and branches

  // Write-back data has to be resolved by the time it lands here
  assert property (@(posedge CLK) disable iff (RST) wrEn |-> !$isunknown(wrData))
    else $error("Register write with unknown data");

endmodule

`default_nettype wire

// ==== verilog/dcpuExecute.sv ====
`default_nettype none

module dcpuExecute import dcpuPkg::*; #(
  parameter int addrWidth = 8
) (
  input  wire logic                   CLK,
  input  wire logic                   RST,
  input  wire logic                   Running,
  input  wire instWord_t              fetchInst,
  input  wire logic [dataWidth-1:0]   DataIn,
  input  wire logic [dataWidth-1:0]   rdDataA,
  input  wire logic [dataWidth-1:0]   rdDataB,
  input  wire logic [dataWidth-1:0]   rdDataC,
  output logic [regIdxWidth-1:0]      rdAddrA,
  output logic [regIdxWidth-1:0]      rdAddrB,
  output logic [regIdxWidth-1:0]      rdAddrC,
  output logic                        wrEn,
  output logic [regIdxWidth-1:0]      wrAddr,
  output logic [dataWidth-1:0]        wrData,
  output logic                        redirect,
  output logic [addrWidth-1:0]        target,
  output logic                        haltSeen,
  output logic [addrWidth-1:0]        DataMemAddr,
  output logic                        DataMemWE,
  output logic [dataWidth-1:0]        DataOut
);

  // Decode
  logic [opWidth-1:0]     idOp;
  logic [dataWidth-1:0]   immZext;
  logic [dataWidth-1:0]   immHigh;
  logic [dataWidth-1:0]   offsetZext;
  logic [dataWidth-1:0]   idOpA;
  logic [dataWidth-1:0]   idOpB;

  // Execute
  logic [opWidth-1:0]     exOp;
  logic [regIdxWidth-1:0] exDest;
  logic [dataWidth-1:0]   exA;
  logic [dataWidth-1:0]   exB;
  logic [dataWidth-1:0]   exStore;
  logic [dataWidth-1:0]   aluResult;
  logic                   setsZero;
  logic                   zeroFlag;

  // Memory
  logic [opWidth-1:0]     memOp;
  logic [regIdxWidth-1:0] memDest;
  logic [dataWidth-1:0]   memResult;
  logic [dataWidth-1:0]   memStore;
  logic                   branchTaken;

  // Write-back
  logic [opWidth-1:0]     wbOp;
  logic [regIdxWidth-1:0] wbDest;
  logic [dataWidth-1:0]   wbData;

  function automatic logic isWriter(input logic [opWidth-1:0] op);
    case (op)
      opLoad, opLdil, opLdih, opAdd, opAddi, opSub, opAnd, opOr, opXor: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////
  assign idOp       = fetchInst.regForm.opcode;
  assign rdAddrA    = fetchInst.regForm.srcA;
  assign rdAddrB    = fetchInst.regForm.srcB[regIdxWidth-1:0];
  assign rdAddrC    = fetchInst.immForm.dest;

  assign immZext    = {{(dataWidth-8){1'b0}}, fetchInst.immForm.imm};
  assign immHigh    = {fetchInst.immForm.imm, {(dataWidth-8){1'b0}}};
  assign offsetZext = {{(dataWidth-4){1'b0}}, fetchInst.regForm.srcB};

  always_comb begin
    idOpA = '0;
    idOpB = '0;
    case (idOp)
      opLoad, opStore: begin // Base register plus offset nibble
        idOpA = rdDataA;
        idOpB = offsetZext;
      end
      opLdil, opJump: idOpB = immZext;
      opLdih:         idOpB = immHigh;
      opAddi, opBz, opBnz: begin
        idOpA = rdDataC;
        idOpB = immZext;
      end
      opAdd, opSub, opAnd, opOr, opXor: begin
        idOpA = rdDataA;
        idOpB = rdDataB;
      end
      default: ;
    endcase
  end

  //////////////////////////////////////////////////
  // Execute
  //////////////////////////////////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      exOp <= opNop;
    end else if (Running) begin
      exOp <= idOp;
    end
  end

  always_ff @(posedge CLK) begin
    if (Running) begin
      exDest  <= fetchInst.immForm.dest;
      exA     <= idOpA;
      exB     <= idOpB;
      exStore <= rdDataC;   // Store data comes from dest
    end
  end

  always_comb begin
    case (exOp)
      opSub:   aluResult = exA - exB;
      opAnd:   aluResult = exA & exB;
      opOr:    aluResult = exA | exB;
      opXor:   aluResult = exA ^ exB;
      default: aluResult = exA + exB; // Also addresses, constants and targets
    endcase
  end

  assign setsZero = (exOp == opAdd) || (exOp == opAddi) || (exOp == opSub) ||
                    (exOp == opAnd) || (exOp == opOr) || (exOp == opXor);

  //////////////////////////////////////////////////
  // Memory stage
  //////////////////////////////////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      memOp    <= opNop;
      zeroFlag <= 1'b0;
    end else if (Running) begin
      memOp <= exOp;
      if (setsZero) zeroFlag <= (aluResult == '0);
    end
  end

  always_ff @(posedge CLK) begin
    if (Running) begin
      memDest   <= exDest;
      memResult <= aluResult;
      memStore  <= exStore;
    end
  end

  assign DataMemAddr = memResult[addrWidth-1:0];
  assign DataOut     = memStore;
  assign DataMemWE   = Running && (memOp == opStore); // Held stage must not store twice

  assign branchTaken = (memOp == opJump) ||
                       ((memOp == opBz) && zeroFlag) ||
                       ((memOp == opBnz) && !zeroFlag);
  assign redirect    = Running && branchTaken;
  assign target      = memResult[addrWidth-1:0];

  //////////////////////////////////////////////////
  // Write-back
  //////////////////////////////////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wbOp <= opNop;
    end else if (Running) begin
      wbOp <= memOp;
    end else begin
      wbOp <= opNop;  // Only stage flushed while idle
    end
  end

  always_ff @(posedge CLK) begin
    if (Running) begin
      wbDest <= memDest;
      wbData <= (memOp == opLoad) ? DataIn : memResult;
    end
  end

  assign wrEn     = isWriter(wbOp);
  assign wrAddr   = wbDest;
  assign wrData   = wbData;
  assign haltSeen = (wbOp == opHalt);

  // A store and a taken branch never share the memory stage
  assert property (@(posedge CLK) disable iff (RST) !(DataMemWE && redirect))
    else $error("Store and redirect in the same cycle");

  // Fetch only takes the redirect target while it runs
  assert property (@(posedge CLK) disable iff (RST) redirect |-> Running)
    else $error("Redirect while the CPU is idle");

endmodule

`default_nettype wire

// ==== verilog/dcpuTop.sv ====
`default_nettype none

module dcpuTop import dcpuPkg::*; #(
  parameter int addrWidth = 8
) (
  input  wire logic                 CLK,
  input  wire logic                 RST,
  input  wire logic                 EN,
  input  wire logic                 Start,
  input  wire instWord_t            Inst,
  input  wire logic [dataWidth-1:0] DataIn,
  output logic [addrWidth-1:0]      InstMemAddr,
  output logic [addrWidth-1:0]      DataMemAddr,
  output logic                      DataMemWE,
  output logic [dataWidth-1:0]      DataOut,
  output logic                      Running
);

  instWord_t              fetchInst;
  logic                   redirect;
  logic [addrWidth-1:0]   target;
  logic                   haltSeen;

  // Register file ports
  logic [regIdxWidth-1:0] rdAddrA;
  logic [regIdxWidth-1:0] rdAddrB;
  logic [regIdxWidth-1:0] rdAddrC;
  logic [dataWidth-1:0]   rdDataA;
  logic [dataWidth-1:0]   rdDataB;
  logic [dataWidth-1:0]   rdDataC;
  logic                   wrEn;
  logic [regIdxWidth-1:0] wrAddr;
  logic [dataWidth-1:0]   wrData;

  //////////////////////////////////////////////////
  // Fetch
  //////////////////////////////////////////////////
  dcpuFetch #(.addrWidth(addrWidth)) dcpuFetch_i (
    .CLK         (CLK),
    .RST         (RST),
    .EN          (EN),
    .Start       (Start),
    .Inst        (Inst),
    .redirect    (redirect),
    .target      (target),
    .haltSeen    (haltSeen),
    .InstMemAddr (InstMemAddr),
    .fetchInst   (fetchInst),
    .Running     (Running)
  );

  dcpuRegFile dcpuRegFile_i (
    .CLK     (CLK),
    .RST     (RST),
    .rdAddrA (rdAddrA),
    .rdAddrB (rdAddrB),
    .rdAddrC (rdAddrC),
    .wrEn    (wrEn),
    .wrAddr  (wrAddr),
    .wrData  (wrData),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB),
    .rdDataC (rdDataC)
  );

  //////////////////////////////////////////////////
  // Decode through write-back
  //////////////////////////////////////////////////
  dcpuExecute #(.addrWidth(addrWidth)) dcpuExecute_i (
    .CLK         (CLK),
    .RST         (RST),
    .Running     (Running),
    .fetchInst   (fetchInst),
    .DataIn      (DataIn),
    .rdDataA     (rdDataA),
    .rdDataB     (rdDataB),
    .rdDataC     (rdDataC),
    .rdAddrA     (rdAddrA),
    .rdAddrB     (rdAddrB),
    .rdAddrC     (rdAddrC),
    .wrEn        (wrEn),
    .wrAddr      (wrAddr),
    .wrData      (wrData),
    .redirect    (redirect),
    .target      (target),
    .haltSeen    (haltSeen),
    .DataMemAddr (DataMemAddr),
    .DataMemWE   (DataMemWE),
    .DataOut     (DataOut)
  );

endmodule

`default_nettype wire

// ==== sim/tbPrograms.svh ====
// Test table, one entry per test: name, program words from address 0,
// data preload addresses and the ordered list of expected stores

localparam int numTests  = 5;
localparam int progLen   = 40;
localparam int maxPre    = 2;
localparam int maxStores = 5;

string testName [numTests] = '{"constants", "aluOps", "loadAddi", "branches", "haltPause"};

// Running cycles before EN drops for a pause, zero for none
int pauseAt [numTests] = '{0, 0, 0, 4, 7};

// Rest of instruction memory is NOP
logic [15:0] progTable [numTests][progLen] = '{
  '{16'h2134, 16'h2A12, 16'h2380, 16'h0000, 16'h0000, 16'h0000, 16'h1904, 16'h1A35,
    16'h1B00, 16'h0800, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
    16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
    16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
    16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
  '{16'h21F0, 16'h2A0F, 16'h233C, 16'h0000, 16'h0000, 16'h0000, 16'h8412, 16'h9D31,
    16'hD613, 16'hDF23, 16'hC913, 16'h0000, 16'h0000, 16'h0000, 16'h1C01, 16'h1D02,
    16'h1E03, 16'h1F04, 16'h1905, 16'h0800, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
    16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
    16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
  '{16'h2240, 16'h1107, 16'h0000, 16'h0000, 16'h1329, 16'h8925, 16'h0000, 16'h0000,
    16'h8BFF, 16'h192A, 16'h0000, 16'h0000, 16'h1B2F, 16'h0800, 16'h0000, 16'h0000,
    16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
    16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
    16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
  // JUMP to 8, BNZ/BZ on a zero SUB, BZ/BNZ on a nonzero ADD to r6 plus 3
  '{16'h2111, 16'h2222, 16'h3008, 16'h2620, 16'h0000, 16'h1901, 16'h1A02, 16'h0800,
    16'h9B11, 16'h4820, 16'h0000, 16'h0000, 16'h0000, 16'h4018, 16'h1A03, 16'h0000,
    16'h0000, 16'h1904, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
    16'h8412, 16'h4008, 16'h0000, 16'h0000, 16'h0000, 16'h4E03, 16'h1C05, 16'h0000,
    16'h0000, 16'h1A06, 16'h1907, 16'h1A08, 16'h0800, 16'h0000, 16'h0000, 16'h0000},
  // STORE two slots after HALT would reach memory if Running fell late
  '{16'h215A, 16'h2AA5, 16'h0000, 16'h0000, 16'h1901, 16'h8312, 16'h0000, 16'h0000,
    16'h0000, 16'h1B02, 16'hCC31, 16'h0000, 16'h0000, 16'h0000, 16'h1C03, 16'h0800,
    16'h0000, 16'h1909, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
    16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
    16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000}
};

// Preload addresses, the values come from the random generator
int                   preCount [numTests] = '{0, 0, 2, 0, 0};
logic [addrWidth-1:0] preAddr [numTests][maxPre] = '{'{0, 0}, '{0, 0}, '{8'h07, 8'h49},
                                                     '{0, 0}, '{0, 0}};

// Expected store: address, constant, index of the preload added (-1 for none)
int                   expCount [numTests] = '{3, 5, 2, 4, 3};
logic [addrWidth-1:0] expAddr [numTests][maxStores] = '{
  '{8'h04, 8'h85, 8'h00, 0, 0}, '{1, 2, 3, 4, 5}, '{8'h4A, 8'h4F, 0, 0, 0},
  '{1, 3, 5, 8, 0}, '{1, 2, 3, 0, 0}};
logic [15:0]          expConst [numTests][maxStores] = '{
  '{16'h0034, 16'h1200, 16'h0080, 0, 0},
  '{16'h0FF0, 16'hFF4C, 16'h0030, 16'h0F3C, 16'h00CC},
  '{16'h0025, 16'h00FF, 0, 0, 0},
  '{16'h0011, 16'h0022, 16'h0033, 16'h0022, 0},
  '{16'h005A, 16'hA55A, 16'hA500, 0, 0}};
int                   expPre [numTests][maxStores] = '{
  '{-1, -1, -1, -1, -1}, '{-1, -1, -1, -1, -1}, '{0, 1, -1, -1, -1},
  '{-1, -1, -1, -1, -1}, '{-1, -1, -1, -1, -1}};

// ==== sim/tbDcpu.sv ====
`default_nettype none

module tbDcpu import dcpuPkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int addrWidth = 8;
  localparam int memDepth  = 2 ** addrWidth;
  localparam int maxCycles = 500;

  logic                 CLK;
  logic                 RST;
  logic                 EN;
  logic                 Start;
  instWord_t            Inst;
  logic [dataWidth-1:0] DataIn;
  logic [addrWidth-1:0] InstMemAddr;
  logic [addrWidth-1:0] DataMemAddr;
  logic                 DataMemWE;
  logic [dataWidth-1:0] DataOut;
  logic                 Running;

  instWord_t            imem [memDepth];
  logic [dataWidth-1:0] dmem [memDepth];
  logic [addrWidth-1:0] storeAddr [$];
  logic [dataWidth-1:0] storeData [$];
  logic [dataWidth-1:0] preVal [2];
  logic [31:0]          rngState = 32'd85;
  int                   errors = 0;

  `include "tbPrograms.svh"

  dcpuTop #(.addrWidth(addrWidth)) dcpuTop_i (
    .CLK         (CLK),
    .RST         (RST),
    .EN          (EN),
    .Start       (Start),
    .Inst        (Inst),
    .DataIn      (DataIn),
    .InstMemAddr (InstMemAddr),
    .DataMemAddr (DataMemAddr),
    .DataMemWE   (DataMemWE),
    .DataOut     (DataOut),
    .Running     (Running)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  //////////////////////////////////////////////////
  // Memory models
  //////////////////////////////////////////////////
  assign Inst   = imem[InstMemAddr]; // Both answer in the same cycle
  assign DataIn = dmem[DataMemAddr];

  // Mid-cycle, so the memory stage outputs are settled
  always @(negedge CLK) begin
    if (!RST && DataMemWE) begin
      dmem[DataMemAddr] = DataOut;
      storeAddr.push_back(DataMemAddr);
      storeData.push_back(DataOut);
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic checkEqual(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic nextCycle();
    @(posedge CLK);
    #1; // Inputs change just after the edge
  endtask

  task automatic resetDut();
    RST   = 1'b1;
    EN    = 1'b0;
    Start = 1'b0;
    repeat (10) nextCycle();
    RST = 1'b0;
  endtask

  task automatic loadTest(input int t);
    for (int a = 0; a < memDepth; a++) begin
      if (a < progLen) imem[a] = progTable[t][a];
      else imem[a] = '0; // NOP
      dmem[a] = {~a[7:0], a[7:0]};
    end
    for (int p = 0; p < preCount[t]; p++) begin
      rngState = xorshift32(rngState);
      preVal[p] = rngState[15:0];
      dmem[preAddr[t][p]] = preVal[p];
    end
    storeAddr.delete();
    storeData.delete();
  endtask

  task automatic pulseStart();
    EN    = 1'b1;
    Start = 1'b1;
    nextCycle();
    Start = 1'b0;
    if (!Running) begin
      errors++;
      $display("Running did not rise after Start");
    end
  endtask

  // Drop EN, watch the frozen fetch address, then restart
  task automatic pauseRun();
    logic [addrWidth-1:0] heldAddr;
    int                   waitCycles;
    EN = 1'b0;
    waitCycles = 0;
    while (Running && waitCycles < 4) begin
      nextCycle();
      waitCycles++;
    end
    if (Running) begin
      errors++;
      $display("Running stayed high after EN went low");
    end
    heldAddr = InstMemAddr;
    repeat (6) begin
      nextCycle();
      checkEqual(InstMemAddr, heldAddr, "InstMemAddr while paused");
      checkEqual(Running, 1'b0, "Running while paused");
    end
    pulseStart();
  endtask

  task automatic runToHalt(input int t, output bit timedOut);
    int cycles;
    timedOut = 1'b0;
    cycles = 0;
    while (Running && !timedOut) begin
      nextCycle();
      cycles++;
      if (cycles == pauseAt[t]) pauseRun();
      if (cycles >= maxCycles) timedOut = 1'b1;
    end
  endtask

  task automatic checkStores(input int t);
    logic [dataWidth-1:0] expData;
    checkEqual(storeAddr.size(), expCount[t], "store count");
    for (int n = 0; n < expCount[t] && n < storeAddr.size(); n++) begin
      expData = expConst[t][n];
      if (expPre[t][n] >= 0) expData = expData + preVal[expPre[t][n]]; // ADDI on loaded word
      checkEqual(storeAddr[n], expAddr[t][n], $sformatf("store %0d address", n));
      checkEqual(storeData[n], expData, $sformatf("store %0d data", n));
    end
  endtask

  //////////////////////////////////////////////////
  // Test loop
  //////////////////////////////////////////////////
  initial begin
    bit timedOut;
    int failedTests;
    int testsRun;
    int errorsBefore;
    RST   = 1'b1;
    EN    = 1'b0;
    Start = 1'b0;
    failedTests = 0;
    testsRun = 0;
    for (int t = 0; t < numTests; t++) begin
      errorsBefore = errors;
      testsRun++;
      resetDut();
      checkEqual(Running, 1'b0, "Running after reset");
      checkEqual(DataMemWE, 1'b0, "DataMemWE after reset");
      checkEqual(InstMemAddr, '0, "InstMemAddr after reset");
      loadTest(t);
      pulseStart();
      runToHalt(t, timedOut);
      if (timedOut) begin
        errors++;
        failedTests++;
        $display("Test %0d %s: the CPU never halted within %0d cycles", t, testName[t],
                 maxCycles);
        break;
      end
      checkStores(t);
      if (errors != errorsBefore) failedTests++;
      $display("Test %0d %s: %s, %0d stores", t, testName[t],
               (errors == errorsBefore) ? "pass" : "FAIL", storeAddr.size());
    end
    $display("Tests run %0d, failed %0d, errors %0d", testsRun, failedTests, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+sim
verilog/dcpuPkg.sv
verilog/dcpuFetch.sv
verilog/dcpuRegFile.sv
verilog/dcpuExecute.sv
verilog/dcpuTop.sv
sim/tbDcpu.sv

// ==== Bender.yml ====
package:
  name: dcpu

sources:
  - files:
      - verilog/dcpuPkg.sv
      - verilog/dcpuFetch.sv
      - verilog/dcpuRegFile.sv
      - verilog/dcpuExecute.sv
      - verilog/dcpuTop.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tbDcpu.sv
